//--- common/spi_cfg_pkg.sv
// SPI configuration and timing types shared by the clock generator, shifter and FSM.
// The divider and the wait count are both at least 1; a value of 0 is not supported.
// Edge strobes are single-cycle and already corrected for CPOL.

`default_nettype none

package spi_cfg_pkg;

    // ************************************************************
    // widths
    // ************************************************************
    localparam int SPI_DIV_W  = 16;                 // half-period divider width
    localparam int SPI_WAIT_W = 16;                 // inter-packet gap counter width

    // ************************************************************
    // types
    // ************************************************************
    typedef logic [SPI_DIV_W-1:0]  spi_div_t;       // sclk half period in system clocks
    typedef logic [SPI_WAIT_W-1:0] spi_wait_t;      // chip select high gap after a packet

    typedef struct packed {
        logic cpol;                                 // idle level of sclk
        logic cpha;                                 // 1 shifts on the leading edge
    } spi_mode_t;

    typedef struct packed {
        logic lead;                                 // first edge of an sclk period
        logic trail;                                // second edge of an sclk period
        logic word_done;                            // final trailing edge of the word
    } spi_edges_t;

endpackage

`default_nettype wire

//--- common/spi_stream_pkg.sv
// Data path types for the stream ports and the SPI pins.
// The word width is fixed at build time; words go out MSB first.

`default_nettype none

package spi_stream_pkg;

    localparam int SPI_DATA_W = 8;                  // bits per SPI word
    localparam int SPI_EDGES  = 2 * SPI_DATA_W;     // sclk edges per word

    typedef logic [SPI_DATA_W-1:0] spi_word_t;

    typedef struct packed {
        spi_word_t data;
        logic      last;                            // closes the packet, chip select is released
    } spi_beat_t;

    typedef struct packed {
        logic sclk;
        logic mosi;
    } spi_pins_t;

endpackage

`default_nettype wire

//--- design/spi_clk_gen.sv
// SCLK generator with CPOL-relative edge strobes.
// Counters clear and sclk parks at CPOL whenever enable_i is low.
// After SPI_EDGES edges the generator holds until it is disabled again.

`timescale 1ns/1ns
`default_nettype none

module spi_clk_gen (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    enable_i,
    input  spi_cfg_pkg::spi_mode_t  mode_i,
    input  spi_cfg_pkg::spi_div_t   div_i,
    output logic                    sclk_o,
    output spi_cfg_pkg::spi_edges_t edges_o
);

    import spi_cfg_pkg::*;
    import spi_stream_pkg::*;

    localparam int EDGE_W = $clog2(SPI_EDGES + 1);

    spi_div_t          div_cnt_q;
    logic [EDGE_W-1:0] edge_cnt_q;
    logic              sclk_q;
    logic              active;
    logic              tick;

    // edges remain while the count has not reached a full word
    assign active = enable_i && (edge_cnt_q != EDGE_W'(SPI_EDGES));
    assign tick   = active && (div_cnt_q == div_i - 1'b1);

    // ************************************************************
    // divider and edge counter
    // ************************************************************
    always_ff @(posedge clk_i) begin
        if (!rstn_i || !enable_i) begin
            div_cnt_q  <= '0;
            edge_cnt_q <= '0;
            sclk_q     <= mode_i.cpol;                 // idle level follows polarity
        end else if (active) begin
            if (tick) begin
                div_cnt_q  <= '0;
                edge_cnt_q <= edge_cnt_q + 1'b1;
                sclk_q     <= ~sclk_q;
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
        end
    end

    // even edge counts are leading edges since sclk starts at CPOL
    assign edges_o = '{
        lead:      tick && !edge_cnt_q[0],
        trail:     tick && edge_cnt_q[0],
        word_done: tick && (edge_cnt_q == EDGE_W'(SPI_EDGES - 1))
    };

    assign sclk_o = sclk_q;

endmodule

`default_nettype wire

//--- design/spi_shift.sv
// MSB-first shift register for one SPI word.
// CPHA 0 presents the first bit at load, samples on lead and shifts on trail.
// CPHA 1 shifts on lead and samples on trail; MOSI holds the last bit after the word.

`timescale 1ns/1ns
`default_nettype none

module spi_shift (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    load_i,
    input  spi_stream_pkg::spi_word_t tx_i,
    input  logic                    cpha_i,
    input  spi_cfg_pkg::spi_edges_t edges_i,
    input  logic                    miso_i,
    output logic                    mosi_o,
    output spi_stream_pkg::spi_word_t rx_o
);

    import spi_stream_pkg::*;

    spi_word_t tx_q;
    spi_word_t rx_q;
    logic      mosi_q;
    logic      shift_en;
    logic      sample_en;

    // the final trailing edge has no next bit to present
    assign shift_en  = (cpha_i ? edges_i.lead : edges_i.trail) && !edges_i.word_done;
    assign sample_en = cpha_i ? edges_i.trail : edges_i.lead;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mosi_q <= 1'b0;
        end else if (load_i) begin
            mosi_q <= tx_i[SPI_DATA_W-1];                  // first bit is on the pin early
        end else if (shift_en) begin
            mosi_q <= tx_q[SPI_DATA_W-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            // with cpha 0 the msb already sits on mosi, so skip it
            tx_q <= cpha_i ? tx_i : {tx_i[SPI_DATA_W-2:0], 1'b0};
        end else if (shift_en) begin
            tx_q <= {tx_q[SPI_DATA_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_en) begin
            rx_q <= {rx_q[SPI_DATA_W-2:0], miso_i};        // first sampled bit ends up as msb
        end
    end

    assign mosi_o = mosi_q;
    assign rx_o   = rx_q;

endmodule

`default_nettype wire

//--- design/spi_ctrl_fsm.sv
// Transfer control: input handshake, chip select and the inter-packet gap.
// A word is accepted only in IDLE with the output buffer empty and no load pending.
// addr_i, wait_i and the other configuration inputs must stay stable during a word.

`timescale 1ns/1ns
`default_nettype none

module spi_ctrl_fsm #(
    parameter  int SLAVE_NUM = 4,
    localparam int ADDR_W    = (SLAVE_NUM > 1) ? $clog2(SLAVE_NUM) : 1
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    s_valid_i,
    input  logic                    s_last_i,
    output logic                    s_ready_o,
    input  logic [ADDR_W-1:0]       addr_i,
    input  spi_cfg_pkg::spi_wait_t  wait_i,
    input  spi_cfg_pkg::spi_edges_t edges_i,
    input  logic                    buf_full_i,
    output logic                    start_o,
    output logic                    enable_o,
    output logic                    load_o,
    output logic                    last_o,
    output logic [SLAVE_NUM-1:0]    cs_n_o
);

    import spi_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        WAIT
    } state_e;

    state_e            state_q;
    logic              last_q;
    logic              cs_act_q;
    logic              load_q;
    logic [ADDR_W-1:0] addr_q;
    spi_wait_t         wait_cnt_q;
    logic              accept;

    // a pending load counts as a held word, so nothing can be overwritten
    assign s_ready_o = rstn_i && (state_q == IDLE) && !buf_full_i && !load_q;
    assign accept    = s_valid_i && s_ready_o;
    assign start_o   = accept;
    assign enable_o  = (state_q == DATA) || (state_q == WAIT);
    assign load_o    = load_q;                              // rx word is complete one clock later
    assign last_o    = last_q;

    // ************************************************************
    // state machine
    // ************************************************************
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= IDLE;
            last_q     <= 1'b0;
            cs_act_q   <= 1'b0;
            load_q     <= 1'b0;
            wait_cnt_q <= '0;
        end else begin
            load_q <= edges_i.word_done;
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q  <= DATA;
                        last_q   <= s_last_i;
                        cs_act_q <= 1'b1;                   // stays low across a packet
                    end
                end
                DATA: begin
                    if (edges_i.word_done) begin
                        if (last_q) begin
                            state_q  <= WAIT;
                            cs_act_q <= 1'b0;
                        end else begin
                            state_q <= IDLE;
                        end
                    end
                end
                WAIT: begin
                    if (wait_cnt_q == wait_i - 1'b1) begin
                        wait_cnt_q <= '0;
                        state_q    <= IDLE;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= addr_i;
        end
    end

    // one-hot active-low select of the latched slave
    always_comb begin
        for (int i = 0; i < SLAVE_NUM; i++) begin
            cs_n_o[i] = !(cs_act_q && (addr_q == ADDR_W'(i)));
        end
    end

endmodule

`default_nettype wire

//--- design/spi_rx_buffer.sv
// One-entry output register for received words.
// The FSM never loads it while a word is still held.

`timescale 1ns/1ns
`default_nettype none

module spi_rx_buffer (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      load_i,
    input  logic                      last_i,
    input  spi_stream_pkg::spi_word_t rx_i,
    input  logic                      m_ready_i,
    output spi_stream_pkg::spi_beat_t m_beat_o,
    output logic                      m_valid_o,
    output logic                      full_o
);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            m_valid_o <= 1'b0;
        end else if (load_i) begin
            m_valid_o <= 1'b1;
        end else if (m_valid_o && m_ready_i) begin
            m_valid_o <= 1'b0;                              // handshake empties the entry
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            m_beat_o.data <= rx_i;
            m_beat_o.last <= last_i;
        end
    end

    assign full_o = m_valid_o;

endmodule

`default_nettype wire

//--- design/spi_master_top.sv
// SPI master with stream ports, all four modes and one-hot active-low chip select.
// Configuration inputs are used at acceptance and must not change while a word shifts.
// Word width is fixed by the data package; only SLAVE_NUM varies per instance.

`timescale 1ns/1ns
`default_nettype none

module spi_master_top #(
    parameter  int SLAVE_NUM = 4,
    localparam int ADDR_W    = (SLAVE_NUM > 1) ? $clog2(SLAVE_NUM) : 1
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  spi_stream_pkg::spi_beat_t s_beat_i,
    input  logic                      s_valid_i,
    output logic                      s_ready_o,
    output spi_stream_pkg::spi_beat_t m_beat_o,
    output logic                      m_valid_o,
    input  logic                      m_ready_i,
    output spi_stream_pkg::spi_pins_t spi_pins_o,
    output logic [SLAVE_NUM-1:0]      cs_n_o,
    input  logic                      miso_i,
    input  spi_cfg_pkg::spi_mode_t    mode_i,
    input  spi_cfg_pkg::spi_div_t     div_i,
    input  spi_cfg_pkg::spi_wait_t    wait_i,
    input  logic [ADDR_W-1:0]         addr_i
);

    import spi_cfg_pkg::*;
    import spi_stream_pkg::*;

    spi_edges_t edges;
    spi_word_t  rx_word;
    logic       start;
    logic       enable;
    logic       load;
    logic       last;
    logic       buf_full;
    logic       sclk;
    logic       mosi;

    // ************************************************************
    // control and clocking
    // ************************************************************
    spi_ctrl_fsm #(
        .SLAVE_NUM(SLAVE_NUM)
    ) i_ctrl (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .s_valid_i (s_valid_i),
        .s_last_i  (s_beat_i.last),
        .s_ready_o (s_ready_o),
        .addr_i    (addr_i),
        .wait_i    (wait_i),
        .edges_i   (edges),
        .buf_full_i(buf_full),
        .start_o   (start),
        .enable_o  (enable),
        .load_o    (load),
        .last_o    (last),
        .cs_n_o    (cs_n_o)
    );

    spi_clk_gen i_clk_gen (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .enable_i(enable),
        .mode_i  (mode_i),
        .div_i   (div_i),
        .sclk_o  (sclk),
        .edges_o (edges)
    );

    // ************************************************************
    // data path
    // ************************************************************
    spi_shift i_shift (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .load_i (start),                                    // tx word enters at acceptance
        .tx_i   (s_beat_i.data),
        .cpha_i (mode_i.cpha),
        .edges_i(edges),
        .miso_i (miso_i),
        .mosi_o (mosi),
        .rx_o   (rx_word)
    );

    spi_rx_buffer i_rx_buf (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .load_i   (load),
        .last_i   (last),
        .rx_i     (rx_word),
        .m_ready_i(m_ready_i),
        .m_beat_o (m_beat_o),
        .m_valid_o(m_valid_o),
        .full_o   (buf_full)
    );

    assign spi_pins_o = '{sclk: sclk, mosi: mosi};

endmodule

`default_nettype wire

//--- verification/spi_master_asserts.sv
// Protocol assertions for spi_master_top, attached to every instance with bind.
// Mode changes are only allowed while the master is between words.

`timescale 1ns/1ns
`default_nettype none

module spi_master_asserts #(
    parameter int SLAVE_NUM = 4
) (
    input logic                      clk_i,
    input logic                      rstn_i,
    input logic [SLAVE_NUM-1:0]      cs_n_o,
    input spi_stream_pkg::spi_pins_t spi_pins_o,
    input spi_cfg_pkg::spi_mode_t    mode_i,
    input spi_stream_pkg::spi_beat_t m_beat_o,
    input logic                      m_valid_o,
    input logic                      m_ready_i,
    input logic                      s_ready_o
);

    int unsigned fail_cnt = 0;                          // number of failed assertions

    a_cs_one_hot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $countones(~cs_n_o) <= 1)
        else begin
            fail_cnt++;
            $error("more than one chip select is low");
        end

    // sclk follows a new polarity one clock late
    a_sclk_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (&cs_n_o && $stable(mode_i)) |-> (spi_pins_o.sclk == mode_i.cpol))
        else begin
            fail_cnt++;
            $error("sclk is away from cpol while no slave is selected");
        end

    a_out_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_beat_o)))
        else begin
            fail_cnt++;
            $error("output beat changed or dropped under back-pressure");
        end

    a_no_accept_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        m_valid_o |-> !s_ready_o)
        else begin
            fail_cnt++;
            $error("input ready while the output buffer is full");
        end

endmodule

bind spi_master_top spi_master_asserts #(
    .SLAVE_NUM(SLAVE_NUM)
) i_asserts (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .cs_n_o    (cs_n_o),
    .spi_pins_o(spi_pins_o),
    .mode_i    (mode_i),
    .m_beat_o  (m_beat_o),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i),
    .s_ready_o (s_ready_o)
);

`default_nettype wire

//--- verification/tb_spi_master.sv
// Testbench for spi_master_top with a loopback slave, MISO tied straight to MOSI.
// Sends forty words in each SPI mode with random data, packet length, divider, gap,
// address and output stalls. Configuration changes only when the DUT is ready for a word.
// Protocol rules on the pins and streams are also covered by the bound assertion module.

`timescale 1ns/1ns
`default_nettype none

module tb_spi_master;

    import spi_cfg_pkg::*;
    import spi_stream_pkg::*;

    localparam int SLAVE_NUM      = 4;
    localparam int ADDR_W         = $clog2(SLAVE_NUM);
    localparam int WORDS_PER_MODE = 40;
    localparam int N_WORDS        = 4 * WORDS_PER_MODE;
    localparam int WORD_NS        = (SPI_EDGES * 4 + 6 + 10) * 4;  // slowest divider, longest gap
    localparam int TIMEOUT_NS     = 2 * N_WORDS * WORD_NS + 1000;  // doubled to cover output stalls

    logic                 clk;
    logic                 rstn;
    spi_beat_t            s_beat;
    logic                 s_valid;
    logic                 s_ready;
    spi_beat_t            m_beat;
    logic                 m_valid;
    logic                 m_ready;
    spi_pins_t            pins;
    logic [SLAVE_NUM-1:0] cs_n;
    logic                 miso;
    spi_mode_t            cfg_mode;
    spi_div_t             cfg_div;
    spi_wait_t            cfg_wait;
    logic [ADDR_W-1:0]    cfg_addr;

    spi_mode_t            pkt_mode;                     // settings of the packet being sent
    spi_div_t             pkt_div;
    spi_wait_t            pkt_wait;
    logic [ADDR_W-1:0]    pkt_addr;
    logic [ADDR_W-1:0]    cur_addr = '0;                // settings of the word last accepted
    logic                 cur_cpol = 1'b0;
    logic                 cur_last = 1'b0;
    spi_div_t             cur_div  = '0;
    spi_wait_t            cur_wait = '0;
    logic                 word_start = 1'b0;

    spi_beat_t            exp_q[$];                     // sent beats not yet seen at the output
    int                   value_errors = 0;
    int                   other_errors = 0;
    int                   rx_count     = 0;
    int                   stall_left   = 0;
    int                   since        = 0;             // clocks since the last sclk toggle
    int                   tog_cnt      = 0;
    int                   gap_cnt      = 0;
    int                   words_seen   = 0;
    logic                 in_word      = 1'b0;
    logic                 prev_sclk    = 1'b0;
    logic                 prev_cs_high = 1'b1;
    logic                 gap_armed    = 1'b0;
    spi_wait_t            gap_wait     = '0;

    spi_master_top #(
        .SLAVE_NUM(SLAVE_NUM)
    ) dut (
        .clk_i     (clk),
        .rstn_i    (rstn),
        .s_beat_i  (s_beat),
        .s_valid_i (s_valid),
        .s_ready_o (s_ready),
        .m_beat_o  (m_beat),
        .m_valid_o (m_valid),
        .m_ready_i (m_ready),
        .spi_pins_o(pins),
        .cs_n_o    (cs_n),
        .miso_i    (miso),
        .mode_i    (cfg_mode),
        .div_i     (cfg_div),
        .wait_i    (cfg_wait),
        .addr_i    (cfg_addr)
    );

    assign miso = pins.mosi;                            // loopback slave, every mode returns the word

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        value_errors++;
        $display("FAIL %s: expected 0x%0h, actual 0x%0h at %0t ns", name, exp, act, $time);
    endtask

    task automatic other_error(input string what);
        other_errors++;
        $display("ERROR: %s at %0t ns", what, $time);
    endtask

    // waits for ready, then presents the word together with the packet settings
    task automatic send_word(input spi_word_t data, input logic last);
        @(negedge clk);
        while (!s_ready) @(negedge clk);
        cfg_mode = pkt_mode;
        cfg_div  = pkt_div;
        cfg_wait = pkt_wait;
        cfg_addr = pkt_addr;
        s_beat   = '{data: data, last: last};
        s_valid  = 1'b1;
        @(posedge clk);                                 // ready was high, so the word is taken here
        exp_q.push_back(s_beat);
        cur_addr   = pkt_addr;
        cur_cpol   = pkt_mode.cpol;
        cur_last   = last;
        cur_div    = pkt_div;
        cur_wait   = pkt_wait;
        word_start = 1'b1;
        @(negedge clk);
        s_valid = 1'b0;
        repeat ($urandom % 3) @(negedge clk);
    endtask

    initial begin : clock
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: %0d of %0d words received after %0d ns",
                 rx_count, N_WORDS, TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    // ************************************************************
    // pin monitor: chip select, sclk shape and packet gap
    // ************************************************************
    always @(negedge clk) begin
        if (rstn) begin
            if (&cs_n) begin
                if (!prev_cs_high) begin
                    gap_cnt   = 0;
                    gap_wait  = cur_wait;               // gap required by the packet just closed
                    gap_armed = 1'b1;
                end
                gap_cnt++;
            end else begin
                assert (cs_n == ~(SLAVE_NUM'(1) << cur_addr))
                    else value_error("chip_select", SLAVE_NUM'(~(SLAVE_NUM'(1) << cur_addr)), cs_n);
                if (prev_cs_high && gap_armed) begin
                    assert (gap_cnt >= int'(gap_wait))
                        else value_error("packet_gap_min", gap_wait, gap_cnt);
                    gap_armed = 1'b0;
                end
            end
            prev_cs_high = &cs_n;
            if (word_start) begin
                if (words_seen > 0) begin
                    assert (tog_cnt == SPI_EDGES)
                        else value_error("sclk_toggles", SPI_EDGES, tog_cnt);
                end
                word_start = 1'b0;                      // a polarity change here is not a toggle
                tog_cnt    = 0;
                since      = 0;
                in_word    = 1'b1;
                words_seen++;
            end else begin
                since++;
                if (pins.sclk != prev_sclk) begin
                    assert (in_word) else other_error("sclk toggled outside a word");
                    assert (since == int'(cur_div))
                        else value_error("sclk_interval", cur_div, since);
                    since = 0;
                    tog_cnt++;
                    if (tog_cnt == SPI_EDGES) begin
                        in_word = 1'b0;
                        // chip select is released with the final edge of a packet only
                        assert ((&cs_n) == cur_last)
                            else value_error("cs_release", cur_last, &cs_n);
                    end
                end else if (!in_word) begin
                    assert (pins.sclk == cur_cpol)
                        else value_error("sclk_idle", cur_cpol, pins.sclk);
                end
            end
        end
        prev_sclk = pins.sclk;
    end

    // output side: random stalls with long bursts, and the scoreboard
    initial begin : receive
        spi_beat_t exp;
        m_ready = 1'b0;
        wait (rstn);
        forever begin
            @(negedge clk);
            if (stall_left > 0) begin
                m_ready = 1'b0;
                stall_left--;
            end else if ($urandom % 64 == 0) begin
                m_ready    = 1'b0;
                stall_left = 8 + $urandom % 24;
            end else begin
                m_ready = ($urandom % 4) != 0;
            end
            if (m_valid && m_ready) begin           // beat is taken at the next rising edge
                if (exp_q.size() == 0) begin
                    other_error("output word with no word sent");
                end else begin
                    exp = exp_q.pop_front();
                    assert (m_beat.data == exp.data)
                        else value_error("loopback_data", exp.data, m_beat.data);
                    assert (m_beat.last == exp.last)
                        else value_error("loopback_last", exp.last, m_beat.last);
                end
                rx_count++;
            end
        end
    end

    // ************************************************************
    // stimulus and verdict
    // ************************************************************
    initial begin : stimulus
        int words_left;
        int pkt_len;
        int asrt_errors;
        void'($urandom(67));
        rstn     = 1'b0;
        s_beat   = '0;
        s_valid  = 1'b0;
        cfg_mode = '0;
        cfg_div  = spi_div_t'(1);
        cfg_wait = spi_wait_t'(1);
        cfg_addr = '0;
        repeat (8) @(negedge clk);
        assert (&cs_n) else value_error("reset_cs_n", {SLAVE_NUM{1'b1}}, cs_n);
        assert (!m_valid) else value_error("reset_m_valid", 0, m_valid);
        assert (!s_ready) else value_error("reset_s_ready", 0, s_ready);
        assert (pins.sclk == cfg_mode.cpol)
            else value_error("reset_sclk", cfg_mode.cpol, pins.sclk);
        rstn = 1'b1;
        for (int m = 0; m < 4; m++) begin
            words_left = WORDS_PER_MODE;
            while (words_left > 0) begin
                pkt_len = 1 + $urandom % 4;
                // each mode ends on a closed packet
                if (pkt_len > words_left) begin
                    pkt_len = words_left;
                end
                pkt_mode = '{cpol: m[1], cpha: m[0]};
                pkt_div  = spi_div_t'(1 + $urandom % 4);
                pkt_wait = spi_wait_t'(1 + $urandom % 6);
                pkt_addr = ADDR_W'($urandom % SLAVE_NUM);
                for (int w = 0; w < pkt_len; w++) begin
                    send_word(spi_word_t'($urandom), w == pkt_len - 1);
                end
                words_left -= pkt_len;
            end
        end
        wait (rx_count >= N_WORDS);
        repeat (10) @(negedge clk);
        assert (rx_count == N_WORDS) else value_error("words_received", N_WORDS, rx_count);
        assert (exp_q.size() == 0) else value_error("words_outstanding", 0, exp_q.size());
        assert (tog_cnt == SPI_EDGES) else value_error("sclk_toggles", SPI_EDGES, tog_cnt);
        asrt_errors = int'(dut.i_asserts.fail_cnt);
        $display("errors: value %0d, other %0d, assertion %0d",
                 value_errors, other_errors, asrt_errors);
        if (value_errors + other_errors + asrt_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/spi_cfg_pkg.sv
common/spi_stream_pkg.sv
design/spi_clk_gen.sv
design/spi_shift.sv
design/spi_ctrl_fsm.sv
design/spi_rx_buffer.sv
design/spi_master_top.sv
verification/spi_master_asserts.sv
verification/tb_spi_master.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  - common/spi_cfg_pkg.sv
  - common/spi_stream_pkg.sv
  - design/spi_clk_gen.sv
  - design/spi_shift.sv
  - design/spi_ctrl_fsm.sv
  - design/spi_rx_buffer.sv
  - design/spi_master_top.sv
  - target: test
    files:
      - verification/spi_master_asserts.sv
      - verification/tb_spi_master.sv
